// File: logic/rom_bus_pkg.sv
package rom_bus_pkg;

    // Widest word address any bank may use
    localparam int ROM_ADDR_MAX = 16;

    // What the bank does in one cycle
    typedef enum logic [1:0] {
        OP_NONE  = 2'd0,
        OP_WRITE = 2'd1,
        OP_READ  = 2'd2
    } rom_op_e;

    // Download write toward the bank
    typedef struct packed {
        logic                    we;
        logic [ROM_ADDR_MAX-1:0] addr;  // Word address, low bits used
        logic [15:0]             data;  // Same byte in both halves
        logic [1:0]              mask;  // Set bit writes that byte
    } prog_wr_t;

    // Game side read request
    typedef struct packed {
        logic                    rd;
        logic [ROM_ADDR_MAX-1:0] addr;
    } rom_rd_t;

    // Read response after the fixed latency
    typedef struct packed {
        logic        dok;
        logic [15:0] data;
    } rom_dout_t;

endpackage

// File: logic/board_cfg_pkg.sv
package board_cfg_pkg;

    // Width of the host status word
    localparam int STATUS_W = 32;

    // Fixed status bit positions
    localparam int ST_RST_REQ = 0;
    localparam int ST_FLIP    = 1;
    localparam int ST_PAUSE   = 2;
    localparam int ST_TEST    = 3;
    localparam int ST_FXLEVEL = 4;  // Two bits wide

    // Settings decoded from the status word
    typedef struct packed {
        logic       dip_flip;
        logic       dip_pause;
        logic       dip_test;
        logic [1:0] dip_fxlevel;
        logic [7:0] dipsw;
    } dip_cfg_t;

    // Game reset controller states
    typedef enum logic [1:0] {
        RS_RESET = 2'd0,  // Board reset active
        RS_LOAD  = 2'd1,  // Download in progress
        RS_HOLD  = 2'd2,  // Counting out the reset hold
        RS_RUN   = 2'd3   // Game running
    } rst_state_e;

endpackage

// File: logic/ioctl_packer.sv
module ioctl_packer #(
    parameter int ADDR_W = 10
) (
    input  logic                  sample,
    input  logic                  reset,
    input  logic                  ioctl_wr,
    input  logic [ADDR_W:0]       ioctl_addr,
    input  logic [7:0]            ioctl_data,
    output rom_bus_pkg::prog_wr_t prog_wr
);

    localparam int AW_MAX = rom_bus_pkg::ROM_ADDR_MAX;

    logic              we_q;
    logic [AW_MAX-1:0] addr_q;
    logic [7:0]        byte_q;
    logic [1:0]        mask_q;

    always_ff @(posedge sample) begin
        if (reset) begin
            we_q <= 1'b0;
        end else begin
            we_q <= ioctl_wr;  // One cycle behind the download strobe
        end
    end

    // Payload only moves with a strobe
    always_ff @(posedge sample) begin
        if (ioctl_wr) begin
            addr_q <= AW_MAX'(ioctl_addr[ADDR_W:1]);  // Drop the byte select
            byte_q <= ioctl_data;
            mask_q <= ioctl_addr[0] ? 2'b10 : 2'b01;  // Odd byte goes high
        end
    end

    always_comb begin
        prog_wr.we   = we_q;
        prog_wr.addr = addr_q;
        prog_wr.data = {byte_q, byte_q};
        prog_wr.mask = mask_q;
    end

    // Exactly one byte lane per download write
    a_mask_onehot : assert property (
        @(posedge sample) disable iff (reset)
        prog_wr.we |-> $onehot(prog_wr.mask)
    ) else $error("ioctl_packer: write mask %b is not one-hot", prog_wr.mask);

endmodule

// File: logic/status_regs.sv
module status_regs #(
    parameter int DIPBASE = 16
) (
    input  logic                                sample,
    input  logic                                reset,
    input  logic [board_cfg_pkg::STATUS_W-1:0]  status,
    output board_cfg_pkg::dip_cfg_t             dip_cfg,
    output logic                                rst_req_pulse
);

    localparam int STATUS_W = board_cfg_pkg::STATUS_W;

    // DIP byte has to fit inside the status word
    if (DIPBASE + 8 > STATUS_W) begin : g_bad_dipbase
        $error("status_regs: DIPBASE %0d puts the DIP byte past the status word", DIPBASE);
    end

    logic [STATUS_W-1:0] status_q;
    logic                req_q;     // Reset request one cycle back

    always_ff @(posedge sample) begin
        if (reset) begin
            status_q <= '0;
            req_q    <= 1'b0;
        end else begin
            status_q <= status;
            req_q    <= status_q[board_cfg_pkg::ST_RST_REQ];
        end
    end

    // Rising edge of the registered request bit
    assign rst_req_pulse = status_q[board_cfg_pkg::ST_RST_REQ] & ~req_q;

    always_comb begin
        dip_cfg.dip_flip    = status_q[board_cfg_pkg::ST_FLIP];
        dip_cfg.dip_pause   = status_q[board_cfg_pkg::ST_PAUSE];
        dip_cfg.dip_test    = status_q[board_cfg_pkg::ST_TEST];
        dip_cfg.dip_fxlevel = status_q[board_cfg_pkg::ST_FXLEVEL +: 2];
        dip_cfg.dipsw       = status_q[DIPBASE +: 8];   // Game DIP byte
    end

    // A held request must not keep pulsing
    a_pulse_single : assert property (
        @(posedge sample) disable iff (reset)
        rst_req_pulse |=> !rst_req_pulse
    ) else $error("status_regs: reset request pulse lasted more than one cycle");

endmodule

// File: logic/game_reset_ctl.sv
module game_reset_ctl #(
    parameter int RESET_HOLD = 8
) (
    input  logic sample,
    input  logic reset,
    input  logic downloading,
    input  logic rst_req_pulse,
    output logic game_rst,
    output logic dwnld_busy
);

    localparam int CNT_W = $clog2(RESET_HOLD + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(RESET_HOLD - 1);

    board_cfg_pkg::rst_state_e state;
    logic [CNT_W-1:0]          hold_cnt;

    always_ff @(posedge sample) begin
        if (reset) begin
            state    <= board_cfg_pkg::RS_RESET;
            hold_cnt <= '0;
        end else if (downloading) begin
            state    <= board_cfg_pkg::RS_LOAD;  // Download beats any hold
            hold_cnt <= '0;
        end else if (state != board_cfg_pkg::RS_HOLD || rst_req_pulse) begin
            // Entry from reset, end of download or a new request
            state    <= board_cfg_pkg::RS_HOLD;
            hold_cnt <= '0;
            if (state == board_cfg_pkg::RS_RUN && !rst_req_pulse) begin
                state <= board_cfg_pkg::RS_RUN;
            end
        end else if (hold_cnt == CNT_LAST) begin
            state <= board_cfg_pkg::RS_RUN;
        end else begin
            hold_cnt <= hold_cnt + 1'b1;
        end
    end

    assign game_rst   = (state != board_cfg_pkg::RS_RUN);
    assign dwnld_busy = (state == board_cfg_pkg::RS_LOAD);

    a_busy_in_reset : assert property (
        @(posedge sample) disable iff (reset)
        dwnld_busy |-> game_rst
    ) else $error("game_reset_ctl: download busy without game reset");

    a_hold_range : assert property (
        @(posedge sample) disable iff (reset)
        hold_cnt <= CNT_W'(RESET_HOLD)
    ) else $error("game_reset_ctl: hold counter at %0d", hold_cnt);

endmodule

// File: logic/rom_bank.sv
module rom_bank #(
    parameter int ADDR_W   = 10,
    parameter int READ_LAT = 3
) (
    input  logic                   sample,
    input  logic                   reset,
    input  logic                   downloading,
    input  rom_bus_pkg::prog_wr_t  prog_wr,
    input  rom_bus_pkg::rom_rd_t   game_rd,
    output rom_bus_pkg::rom_dout_t game_dout
);

    localparam int DEPTH = 2 ** ADDR_W;

    if (READ_LAT < 1) begin : g_bad_lat
        $error("rom_bank: READ_LAT must be at least 1");
    end
    if (ADDR_W > rom_bus_pkg::ROM_ADDR_MAX) begin : g_bad_addr
        $error("rom_bank: ADDR_W %0d exceeds the bus address width", ADDR_W);
    end

    logic [15:0] mem [DEPTH];

    rom_bus_pkg::rom_op_e op;
    logic [ADDR_W-1:0]    waddr;
    logic [ADDR_W-1:0]    raddr;

    logic [READ_LAT-1:0]  vld;              // One bit per read in flight
    logic [15:0]          dat [READ_LAT];

    assign waddr = prog_wr.addr[ADDR_W-1:0];
    assign raddr = game_rd.addr[ADDR_W-1:0];

    // Write has priority, reads are ignored during a download
    always_comb begin
        if (prog_wr.we) begin
            op = rom_bus_pkg::OP_WRITE;
        end else if (game_rd.rd && !downloading) begin
            op = rom_bus_pkg::OP_READ;
        end else begin
            op = rom_bus_pkg::OP_NONE;
        end
    end

    // Array and read data stages
    always_ff @(posedge sample) begin
        if (op == rom_bus_pkg::OP_WRITE) begin
            if (prog_wr.mask[0]) begin
                mem[waddr][7:0] <= prog_wr.data[7:0];
            end
            if (prog_wr.mask[1]) begin
                mem[waddr][15:8] <= prog_wr.data[15:8];
            end
        end
        dat[0] <= mem[raddr];
        for (int i = 1; i < READ_LAT; i++) begin
            dat[i] <= dat[i-1];
        end
    end

    always_ff @(posedge sample) begin
        if (reset) begin
            vld <= '0;
        end else begin
            vld[0] <= (op == rom_bus_pkg::OP_READ);
            for (int i = 1; i < READ_LAT; i++) begin
                vld[i] <= vld[i-1];
            end
        end
    end

    // Last stage is the response
    always_comb begin
        game_dout.dok  = vld[READ_LAT-1];
        game_dout.data = dat[READ_LAT-1];
    end

    // Every response traces back to an accepted read
    a_dok_has_read : assert property (
        @(posedge sample) disable iff (reset)
        game_dout.dok |-> $past(op == rom_bus_pkg::OP_READ, READ_LAT)
    ) else $error("rom_bank: dok without a read %0d cycles earlier", READ_LAT);

endmodule

// File: logic/frame_top.sv
module frame_top #(
    parameter int ADDR_W     = 10,
    parameter int READ_LAT   = 3,
    parameter int DIPBASE    = 16,
    parameter int RESET_HOLD = 8
) (
    input  logic                               sample,
    input  logic                               reset,
    input  logic                               ioctl_wr,
    input  logic [ADDR_W:0]                    ioctl_addr,   // Byte address
    input  logic [7:0]                         ioctl_data,
    input  logic                               downloading,
    input  logic [board_cfg_pkg::STATUS_W-1:0] status,
    input  rom_bus_pkg::rom_rd_t               game_rd,
    output rom_bus_pkg::rom_dout_t             game_dout,
    output board_cfg_pkg::dip_cfg_t            dip_cfg,
    output logic                               game_rst,
    output logic                               dwnld_busy
);

    rom_bus_pkg::prog_wr_t prog_wr;
    logic                  rst_req_pulse;

    ioctl_packer #(.ADDR_W(ADDR_W)) u_packer (
        .sample     (sample),
        .reset      (reset),
        .ioctl_wr   (ioctl_wr),
        .ioctl_addr (ioctl_addr),
        .ioctl_data (ioctl_data),
        .prog_wr    (prog_wr)
    );

    rom_bank #(.ADDR_W(ADDR_W), .READ_LAT(READ_LAT)) u_rom_bank (
        .sample      (sample),
        .reset       (reset),
        .downloading (downloading),
        .prog_wr     (prog_wr),
        .game_rd     (game_rd),
        .game_dout   (game_dout)
    );

    status_regs #(.DIPBASE(DIPBASE)) u_status (
        .sample        (sample),
        .reset         (reset),
        .status        (status),
        .dip_cfg       (dip_cfg),
        .rst_req_pulse (rst_req_pulse)
    );

    // Game reset follows downloads and host requests
    game_reset_ctl #(.RESET_HOLD(RESET_HOLD)) u_rst_ctl (
        .sample        (sample),
        .reset         (reset),
        .downloading   (downloading),
        .rst_req_pulse (rst_req_pulse),
        .game_rst      (game_rst),
        .dwnld_busy    (dwnld_busy)
    );

endmodule

// File: dv/frame_tb_table.svh
`ifndef FRAME_TB_TABLE_SVH
`define FRAME_TB_TABLE_SVH

typedef enum logic [2:0] {
    DL_BYTE,   // Download one byte
    DL_END,    // Two quiet cycles, then downloading drops
    RD_WORD,   // Single read checked against exp_val
    RD_RAND,   // Back-to-back random reads, data is the count
    RD_IN_DL,  // Reads with downloading high, data is the count
    ST_WRITE,  // Drive status, dip_cfg checked a cycle later
    IDLE       // Wait data cycles
} row_op_e;

typedef struct packed {
    row_op_e     op;
    logic [15:0] addr;
    logic [31:0] data;
    logic [31:0] exp_val;
} row_t;

localparam int TBL_LEN = 29;

// Columns: op, byte or word address, data or count, expected value
localparam row_t TABLE [TBL_LEN] = '{
    '{DL_BYTE,  16'd0, 32'h12, 32'h0},
    '{DL_BYTE,  16'd1, 32'h34, 32'h0},
    '{DL_BYTE,  16'd2, 32'h56, 32'h0},
    '{DL_BYTE,  16'd3, 32'h78, 32'h0},
    '{DL_BYTE,  16'd4, 32'h9A, 32'h0},
    '{DL_BYTE,  16'd5, 32'hBC, 32'h0},
    '{DL_BYTE,  16'd6, 32'hDE, 32'h0},
    '{DL_BYTE,  16'd7, 32'hF0, 32'h0},
    '{DL_END,   16'd0, 32'h0,  32'h0},
    '{RD_WORD,  16'd0, 32'h0,  32'h3412},   // Odd byte lands high
    '{RD_WORD,  16'd1, 32'h0,  32'h7856},
    '{RD_WORD,  16'd2, 32'h0,  32'hBC9A},
    '{RD_WORD,  16'd3, 32'h0,  32'hF0DE},
    '{DL_BYTE,  16'd3, 32'hC3, 32'h0},      // High byte of word 1 only
    '{DL_END,   16'd0, 32'h0,  32'h0},
    '{RD_WORD,  16'd1, 32'h0,  32'hC356},
    '{RD_RAND,  16'd0, 32'd24, 32'h0},
    '{RD_IN_DL, 16'd2, 32'd4,  32'h0},
    '{DL_END,   16'd0, 32'h0,  32'h0},
    '{IDLE,     16'd0, 32'd12, 32'h0},
    '{ST_WRITE, 16'd0, 32'h00A5_0036, 32'({1'b1, 1'b1, 1'b0, 2'b11, 8'hA5})},
    '{ST_WRITE, 16'd0, 32'h005A_0008, 32'({1'b0, 1'b0, 1'b1, 2'b00, 8'h5A})},
    '{ST_WRITE, 16'd0, 32'h0000_0001, 32'({1'b0, 1'b0, 1'b0, 2'b00, 8'h00})},
    '{IDLE,     16'd0, 32'd12, 32'h0},
    '{ST_WRITE, 16'd0, 32'h0003_0013, 32'({1'b1, 1'b0, 1'b0, 2'b01, 8'h03})},
    '{IDLE,     16'd0, 32'd12, 32'h0},      // Held request, no new hold
    '{ST_WRITE, 16'd0, 32'hFF00_0000, 32'({1'b0, 1'b0, 1'b0, 2'b00, 8'h00})},
    '{ST_WRITE, 16'd0, 32'h00FF_0021, 32'({1'b0, 1'b0, 1'b0, 2'b10, 8'hFF})},
    '{IDLE,     16'd0, 32'd12, 32'h0}
};

`endif

// File: dv/frame_tb.sv
module frame_tb;

    localparam int ADDR_W     = 10;
    localparam int READ_LAT   = 3;
    localparam int DIPBASE    = 16;
    localparam int RESET_HOLD = 8;

    `include "frame_tb_table.svh"

    localparam int CYCLE_LIMIT = TBL_LEN * (READ_LAT + RESET_HOLD + 4) + 200;

    logic                               sample = 1'b0;
    logic                               reset;
    logic                               ioctl_wr;
    logic [ADDR_W:0]                    ioctl_addr;
    logic [7:0]                         ioctl_data;
    logic                               downloading;
    logic [board_cfg_pkg::STATUS_W-1:0] status;
    rom_bus_pkg::rom_rd_t               game_rd;
    rom_bus_pkg::rom_dout_t             game_dout;
    board_cfg_pkg::dip_cfg_t            dip_cfg;
    logic                               game_rst;
    logic                               dwnld_busy;

    int          cycle = 0;
    int          seed = 32'h03224543;
    int          err_rd = 0;
    int          err_st = 0;
    int          err_rst = 0;
    int          n_checks = 0;
    logic [15:0] ref_mem [2**ADDR_W];
    int          due_q [$];    // Cycle each response is due
    logic [15:0] exp_q [$];

    // Game reset model
    logic        st0_q;
    logic        st0_prev;
    logic        m_busy;
    int          m_left;       // Cycles until game reset drops
    logic        m_game_rst;

    always #20 sample = ~sample;

    frame_top #(
        .ADDR_W     (ADDR_W),
        .READ_LAT   (READ_LAT),
        .DIPBASE    (DIPBASE),
        .RESET_HOLD (RESET_HOLD)
    ) u_frame_top (
        .sample      (sample),
        .reset       (reset),
        .ioctl_wr    (ioctl_wr),
        .ioctl_addr  (ioctl_addr),
        .ioctl_data  (ioctl_data),
        .downloading (downloading),
        .status      (status),
        .game_rd     (game_rd),
        .game_dout   (game_dout),
        .dip_cfg     (dip_cfg),
        .game_rst    (game_rst),
        .dwnld_busy  (dwnld_busy)
    );

    always @(posedge sample) begin
        cycle <= cycle + 1;
        if (reset) begin
            st0_q    <= 1'b0;
            st0_prev <= 1'b0;
            m_busy   <= 1'b0;
            m_left   <= RESET_HOLD + 1;  // Hold begins on the first edge out of reset
        end else begin
            st0_q    <= status[0];
            st0_prev <= st0_q;
            if (downloading) begin
                m_busy <= 1'b1;
                m_left <= RESET_HOLD;
            end else if (m_busy || (st0_q && !st0_prev)) begin
                m_busy <= 1'b0;   // End of download or a request edge
                m_left <= RESET_HOLD;
            end else if (m_left != 0) begin
                m_left <= m_left - 1;
            end
        end
    end

    assign m_game_rst = m_busy || (m_left != 0);

    always @(posedge sample) begin
        if (cycle >= CYCLE_LIMIT) begin
            $display("Timeout: the table did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic check_outputs();
        int          due;
        logic [15:0] exp_data;
        if (cycle > 0) begin
            if (game_dout.dok) begin
                n_checks++;
                assert (due_q.size() != 0) else begin
                    err_rd++;
                    $display("Read response at %0t with no read outstanding", $time);
                end
                if (due_q.size() != 0) begin
                    due      = due_q.pop_front();
                    exp_data = exp_q.pop_front();
                    assert (cycle == due) else begin
                        err_rd++;
                        $display("Error %0t game_dout.dok cycle got %0d exp %0d",
                                 $time, cycle, due);
                    end
                    assert (game_dout.data == exp_data) else begin
                        err_rd++;
                        $display("Error %0t game_dout.data got %h exp %h",
                                 $time, game_dout.data, exp_data);
                    end
                end
            end else begin
                assert (due_q.size() == 0 || due_q[0] > cycle) else begin
                    err_rd++;
                    $display("Read due in cycle %0d got no response by %0t", due_q[0], $time);
                    due      = due_q.pop_front();
                    exp_data = exp_q.pop_front();
                end
            end
            n_checks++;
            assert (game_rst == m_game_rst) else begin
                err_rst++;
                $display("Error %0t game_rst got %b exp %b", $time, game_rst, m_game_rst);
            end
            assert (dwnld_busy == m_busy) else begin
                err_rst++;
                $display("Error %0t dwnld_busy got %b exp %b", $time, dwnld_busy, m_busy);
            end
        end
    endtask

    // Inputs change only after this returns
    task automatic step();
        @(negedge sample);
        check_outputs();
    endtask

    task automatic drain_reads();
        while (due_q.size() != 0) begin
            step();
        end
    endtask

    task automatic download_byte(input row_t row);
        logic [ADDR_W-1:0] w;
        w = row.addr[ADDR_W:1];
        step();
        downloading = 1'b1;
        ioctl_wr    = 1'b1;
        ioctl_addr  = row.addr[ADDR_W:0];
        ioctl_data  = row.data[7:0];
        if (row.addr[0]) begin
            ref_mem[w][15:8] = row.data[7:0];
        end else begin
            ref_mem[w][7:0] = row.data[7:0];
        end
    endtask

    task automatic end_download();
        step();
        ioctl_wr = 1'b0;
        step();
        step();
        downloading = 1'b0;  // Last write is long done
    endtask

    task automatic read_word(input row_t row);
        step();
        game_rd.rd   = 1'b1;
        game_rd.addr = row.addr;
        due_q.push_back(cycle + READ_LAT);
        exp_q.push_back(row.exp_val[15:0]);
        step();
        game_rd.rd = 1'b0;
        drain_reads();
    endtask

    task automatic read_random(input row_t row);
        int                r;
        logic [ADDR_W-1:0] w;
        for (int i = 0; i < int'(row.data); i++) begin
            step();
            r            = $random(seed);
            w            = ADDR_W'(r[1:0]);  // Words 0 to 3 hold data
            game_rd.rd   = 1'b1;
            game_rd.addr = 16'(w);
            due_q.push_back(cycle + READ_LAT);
            exp_q.push_back(ref_mem[w]);
        end
        step();
        game_rd.rd = 1'b0;
        drain_reads();
    endtask

    task automatic read_in_download(input row_t row);
        for (int i = 0; i < int'(row.data); i++) begin
            step();
            downloading  = 1'b1;
            game_rd.rd   = 1'b1;
            game_rd.addr = row.addr;
        end
        step();
        game_rd.rd = 1'b0;
    endtask

    task automatic write_status(input row_t row);
        step();
        status = row.data;
        step();
        n_checks++;
        assert (dip_cfg == row.exp_val[12:0]) else begin
            err_st++;
            $display("Error %0t dip_cfg got %h exp %h", $time, dip_cfg, row.exp_val[12:0]);
        end
    endtask

    task automatic apply_row(input row_t row);
        case (row.op)
            DL_BYTE:  download_byte(row);
            DL_END:   end_download();
            RD_WORD:  read_word(row);
            RD_RAND:  read_random(row);
            RD_IN_DL: read_in_download(row);
            ST_WRITE: write_status(row);
            default:  repeat (int'(row.data)) step();
        endcase
    endtask

    initial begin
        reset       = 1'b1;
        ioctl_wr    = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        downloading = 1'b0;
        status      = '0;
        game_rd     = '0;
        repeat (16) step();
        reset = 1'b0;
        for (int i = 0; i < TBL_LEN; i++) begin
            apply_row(TABLE[i]);
        end
        drain_reads();
        repeat (4) step();
        $display("Checks %0d, errors: read %0d status %0d reset %0d",
                 n_checks, err_rd, err_st, err_rst);
        if (err_rd + err_st + err_rst == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+dv
logic/rom_bus_pkg.sv
logic/board_cfg_pkg.sv
logic/ioctl_packer.sv
logic/status_regs.sv
logic/game_reset_ctl.sv
logic/rom_bank.sv
logic/frame_top.sv
dv/frame_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the frame testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --assert --top-module frame_tb -Mdir "$build_dir" -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/Vframe_tb" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "TEST PASS" "$log_file"; then
    exit 0
fi
echo "Pass message not found in $log_file"
exit 1
